//--- src/noc_pkg.sv
// Router sizes, route table and types

package noc_pkg;

    // Router geometry
    localparam int NUM_PORTS      = 5;
    localparam int FLIT_WIDTH     = 32;
    localparam int DEST_WIDTH     = 3;
    localparam int PORT_IDX_WIDTH = 3;

    // Flits per input buffer, equal to the credits each output starts with
    localparam int BUFFER_DEPTH = 2;
    localparam int CREDIT_WIDTH = 2;

    // Payload and addressing
    typedef logic [FLIT_WIDTH-1:0]     flit_t;
    typedef logic [DEST_WIDTH-1:0]     dest_t;
    typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

    // One bit per port
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // Counts 0 to BUFFER_DEPTH
    typedef logic [CREDIT_WIDTH-1:0] credit_t;

    // Phase of the packet arriving on an input
    typedef enum logic {
        PKT_HEAD,
        PKT_BODY
    } pkt_state_e;

    // Output port per endpoint, one entry for each of the five endpoints
    localparam port_idx_t ROUTE_TABLE [NUM_PORTS] = '{
        3'd2,
        3'd0,
        3'd4,
        3'd1,
        3'd3
    };

endpackage

//--- src/flit_fifo.sv
// Register FIFO with show-ahead read
`timescale 1ns/100ps

module flit_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    // Storage, written in place
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry is always on the read port
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == 0);
    assign full    = (count == DEPTH);

    // Upstream credit accounting must keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full))
        else $error("flit_fifo: write into a full buffer");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty))
        else $error("flit_fifo: read from an empty buffer");

endmodule

//--- src/input_unit.sv
// Router input port
`timescale 1ns/100ps

module input_unit (
    input  logic                clk,
    input  logic                rst_n,

    input  noc_pkg::flit_t      data_in,
    input  noc_pkg::dest_t      dest_in,
    input  logic                is_tail_in,
    input  logic                send_in,
    input  noc_pkg::port_mask_t pop,
    output logic                credit_out,

    output noc_pkg::port_mask_t request,
    output noc_pkg::flit_t      head_flit,
    output logic                head_tail,
    output noc_pkg::dest_t      head_dest
);

    noc_pkg::pkt_state_e         state;
    logic [noc_pkg::FLIT_WIDTH:0] flit_wr_data;
    logic [noc_pkg::FLIT_WIDTH:0] flit_rd_data;
    logic                        flit_empty;
    logic                        head_write;
    logic                        pop_any;
    logic                        dest_pop;
    noc_pkg::port_idx_t          route;

    // Tracks whether the next arriving flit opens a packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= noc_pkg::PKT_HEAD;
        end else if (send_in) begin
            state <= is_tail_in ? noc_pkg::PKT_HEAD : noc_pkg::PKT_BODY;
        end
    end

    assign head_write   = send_in && (state == noc_pkg::PKT_HEAD);
    assign flit_wr_data = {data_in, is_tail_in};
    assign {head_flit, head_tail} = flit_rd_data;

    // At most one output takes our head in a cycle
    assign pop_any    = |pop;
    assign credit_out = pop_any;

    // Destination leaves with the packet tail
    assign dest_pop = pop_any && head_tail;

    // Flit and tail mark travel together
    flit_fifo #(
        .WIDTH (noc_pkg::FLIT_WIDTH + 1),
        .DEPTH (noc_pkg::BUFFER_DEPTH)
    ) u_flit_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (send_in),
        .wr_data (flit_wr_data),
        .rd_en   (pop_any),
        .rd_data (flit_rd_data),
        .empty   (flit_empty),
        .full    ()
    );

    // One entry per packet, written by head flits only
    flit_fifo #(
        .WIDTH (noc_pkg::DEST_WIDTH),
        .DEPTH (noc_pkg::BUFFER_DEPTH)
    ) u_dest_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (head_write),
        .wr_data (dest_in),
        .rd_en   (dest_pop),
        .rd_data (head_dest),
        .empty   (),
        .full    ()
    );

    assign route = noc_pkg::ROUTE_TABLE[head_dest];

    // One-hot request toward the routed output
    always_comb begin
        request = '0;
        if (!flit_empty) begin
            request[route] = 1'b1;
        end
    end

    // Only the output whose arbiter holds this input may pop it
    a_single_pop: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop))
        else $error("input_unit: popped by more than one output");

endmodule

//--- src/matrix_arbiter.sv
// Packet-locking matrix arbiter
`timescale 1ns/100ps

module matrix_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  noc_pkg::port_mask_t request,
    input  logic                advance,
    input  logic                tail,
    output noc_pkg::port_mask_t grant
);

    // prio[i][j] set means input i beats input j
    noc_pkg::port_mask_t prio [noc_pkg::NUM_PORTS];
    noc_pkg::port_mask_t free_grant;
    noc_pkg::port_mask_t lock_grant;
    logic                locked;

    // A requester wins when no other requester beats it
    always_comb begin
        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            free_grant[i] = request[i];
            for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
                if (request[j] && prio[j][i]) begin
                    free_grant[i] = 1'b0;
                end
            end
        end
    end

    assign grant = locked ? lock_grant : free_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked     <= 1'b0;
            lock_grant <= '0;
            // Lower index wins out of reset
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
                    prio[i][j] <= (i < j);
                end
            end
        end else if (advance) begin
            if (tail) begin
                locked <= 1'b0;
                // Winner drops to lowest priority
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
                        if (grant[i] && (i != j)) begin
                            prio[i][j] <= 1'b0;
                            prio[j][i] <= 1'b1;
                        end
                    end
                end
            end else begin
                locked     <= 1'b1;
                lock_grant <= grant;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("matrix_arbiter: more than one grant");

endmodule

//--- src/output_unit.sv
// Router output port
`timescale 1ns/100ps

module output_unit (
    input  logic                clk,
    input  logic                rst_n,

    input  noc_pkg::port_mask_t request,
    input  noc_pkg::flit_t      head_flit [noc_pkg::NUM_PORTS],
    input  logic                head_tail [noc_pkg::NUM_PORTS],
    input  noc_pkg::dest_t      head_dest [noc_pkg::NUM_PORTS],
    input  logic                credit_in,

    output noc_pkg::flit_t      data_out,
    output noc_pkg::dest_t      dest_out,
    output logic                is_tail_out,
    output logic                send_out,
    output noc_pkg::port_mask_t pop
);

    noc_pkg::port_mask_t grant;
    noc_pkg::port_mask_t ready;
    noc_pkg::credit_t    credits;

    matrix_arbiter u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (request),
        .advance (send_out),
        .tail    (is_tail_out),
        .grant   (grant)
    );

    // One-hot crossbar column
    always_comb begin
        data_out    = '0;
        dest_out    = '0;
        is_tail_out = 1'b0;
        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            if (grant[i]) begin
                data_out    = data_out | head_flit[i];
                dest_out    = dest_out | head_dest[i];
                is_tail_out = is_tail_out | head_tail[i];
            end
        end
    end

    // Granted input must also have a flit waiting
    assign ready    = grant & request;
    assign send_out = (|ready) && (credits != '0);
    assign pop      = send_out ? ready : '0;

    // Downstream buffer space
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= noc_pkg::credit_t'(noc_pkg::BUFFER_DEPTH);
        end else if (credit_in && !send_out) begin
            credits <= credits + 1'b1;
        end else if (!credit_in && send_out) begin
            credits <= credits - 1'b1;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= noc_pkg::BUFFER_DEPTH)
        else $error("output_unit: more credits returned than flits sent");

endmodule

//--- src/noc_router.sv
// Five-port wormhole router
`timescale 1ns/100ps

module noc_router (
    input  logic           clk,
    input  logic           rst_n,

    input  noc_pkg::flit_t data_in     [noc_pkg::NUM_PORTS],
    input  noc_pkg::dest_t dest_in     [noc_pkg::NUM_PORTS],
    input  logic           is_tail_in  [noc_pkg::NUM_PORTS],
    input  logic           send_in     [noc_pkg::NUM_PORTS],
    output logic           credit_out  [noc_pkg::NUM_PORTS],

    output noc_pkg::flit_t data_out    [noc_pkg::NUM_PORTS],
    output noc_pkg::dest_t dest_out    [noc_pkg::NUM_PORTS],
    output logic           is_tail_out [noc_pkg::NUM_PORTS],
    output logic           send_out    [noc_pkg::NUM_PORTS],
    input  logic           credit_in   [noc_pkg::NUM_PORTS]
);

    // Indexed by input for in_*, by output for out_*
    noc_pkg::port_mask_t in_request  [noc_pkg::NUM_PORTS];
    noc_pkg::port_mask_t out_request [noc_pkg::NUM_PORTS];
    noc_pkg::port_mask_t out_pop     [noc_pkg::NUM_PORTS];
    noc_pkg::port_mask_t in_pop      [noc_pkg::NUM_PORTS];
    noc_pkg::flit_t      head_flit   [noc_pkg::NUM_PORTS];
    logic                head_tail   [noc_pkg::NUM_PORTS];
    noc_pkg::dest_t      head_dest   [noc_pkg::NUM_PORTS];

    for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_input
        input_unit u_input (
            .clk        (clk),
            .rst_n      (rst_n),
            .data_in    (data_in[i]),
            .dest_in    (dest_in[i]),
            .is_tail_in (is_tail_in[i]),
            .send_in    (send_in[i]),
            .pop        (in_pop[i]),
            .credit_out (credit_out[i]),
            .request    (in_request[i]),
            .head_flit  (head_flit[i]),
            .head_tail  (head_tail[i]),
            .head_dest  (head_dest[i])
        );
    end

    // Transpose masks between input and output views
    always_comb begin
        for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                out_request[o][i] = in_request[i][o];
                in_pop[i][o]      = out_pop[o][i];
            end
        end
    end

    for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : g_output
        output_unit u_output (
            .clk         (clk),
            .rst_n       (rst_n),
            .request     (out_request[o]),
            .head_flit   (head_flit),
            .head_tail   (head_tail),
            .head_dest   (head_dest),
            .credit_in   (credit_in[o]),
            .data_out    (data_out[o]),
            .dest_out    (dest_out[o]),
            .is_tail_out (is_tail_out[o]),
            .send_out    (send_out[o]),
            .pop         (out_pop[o])
        );
    end

endmodule

//--- test/noc_router_tb.sv
// Wormhole router testbench
`timescale 1ns/100ps

module noc_router_tb;

    typedef struct packed {
        noc_pkg::port_idx_t src;
        noc_pkg::dest_t     dest;
        logic [2:0]         len;
        logic               bp;
    } pkt_row_t;

    localparam int NUM_ROWS       = 10;
    localparam int TIMEOUT_CYCLES = 2000;

    // Source, destination endpoint, flits, random credit delay
    localparam pkt_row_t ROWS [NUM_ROWS] = '{
        '{3'd0, 3'd0, 3'd3, 1'b0},
        '{3'd1, 3'd0, 3'd2, 1'b0},
        '{3'd0, 3'd0, 3'd2, 1'b0},
        '{3'd1, 3'd0, 3'd3, 1'b0},
        '{3'd0, 3'd0, 3'd1, 1'b0},
        '{3'd2, 3'd1, 3'd4, 1'b1},
        '{3'd3, 3'd2, 3'd2, 1'b0},
        '{3'd4, 3'd4, 3'd3, 1'b1},
        '{3'd3, 3'd4, 3'd2, 1'b1},
        '{3'd2, 3'd3, 3'd3, 1'b0}
    };

    logic           clk;
    logic           rst_n;
    noc_pkg::flit_t data_in     [noc_pkg::NUM_PORTS];
    noc_pkg::dest_t dest_in     [noc_pkg::NUM_PORTS];
    logic           is_tail_in  [noc_pkg::NUM_PORTS];
    logic           send_in     [noc_pkg::NUM_PORTS];
    logic           credit_out  [noc_pkg::NUM_PORTS];
    noc_pkg::flit_t data_out    [noc_pkg::NUM_PORTS];
    noc_pkg::dest_t dest_out    [noc_pkg::NUM_PORTS];
    logic           is_tail_out [noc_pkg::NUM_PORTS];
    logic           send_out    [noc_pkg::NUM_PORTS];
    logic           credit_in   [noc_pkg::NUM_PORTS];

    // Per input: flits to send and the output each one must leave on
    noc_pkg::flit_t     send_q  [noc_pkg::NUM_PORTS][$];
    noc_pkg::port_idx_t route_q [noc_pkg::NUM_PORTS][$];
    // Per output: expected flits and cycles at which credits return
    noc_pkg::flit_t     exp_q   [noc_pkg::NUM_PORTS][$];
    int                 ret_q   [noc_pkg::NUM_PORTS][$];

    int   credits        [noc_pkg::NUM_PORTS] = '{default: noc_pkg::BUFFER_DEPTH};
    int   injected       [noc_pkg::NUM_PORTS] = '{default: 0};
    int   delivered      [noc_pkg::NUM_PORTS] = '{default: 0};
    int   pulses         [noc_pkg::NUM_PORTS] = '{default: 0};
    int   expected_flits [noc_pkg::NUM_PORTS] = '{default: 0};
    int   outstanding    [noc_pkg::NUM_PORTS] = '{default: 0};
    int   lock_src       [noc_pkg::NUM_PORTS] = '{default: -1};
    int   last_src       [noc_pkg::NUM_PORTS] = '{default: -1};
    int   cycle;
    int   seed = 69575;
    logic running;

    noc_router uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flit(input noc_pkg::flit_t got, input noc_pkg::flit_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_dest(input noc_pkg::dest_t got, input noc_pkg::dest_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_port(input noc_pkg::port_idx_t got, input noc_pkg::port_idx_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s got %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // Source, packet number and flit index
    function automatic noc_pkg::flit_t make_flit(input int src, input int pkt, input int idx);
        return {8'(src), 16'(pkt), 8'(idx)};
    endfunction

    function automatic logic all_done();
        for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
            if (send_q[p].size() != 0 || exp_q[p].size() != 0 || ret_q[p].size() != 0) begin
                return 1'b0;
            end
            if (outstanding[p] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Input senders and output credit returns
    always @(posedge clk) begin : driver
        noc_pkg::flit_t f;
        int             pkt;
        if (running) begin
            cycle++;
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                if (credits[i] > 0 && send_q[i].size() > 0) begin
                    f   = send_q[i].pop_front();
                    pkt = int'(f[23:8]);
                    data_in[i]    <= f;
                    dest_in[i]    <= ROWS[pkt].dest;
                    is_tail_in[i] <= (int'(f[7:0]) == int'(ROWS[pkt].len) - 1);
                    send_in[i]    <= 1'b1;
                    credits[i]--;
                end else begin
                    send_in[i] <= 1'b0;
                end
            end
            for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                if (ret_q[o].size() > 0 && ret_q[o][0] <= cycle) begin
                    credit_in[o] <= 1'b1;
                    void'(ret_q[o].pop_front());
                end else begin
                    credit_in[o] <= 1'b0;
                end
            end
        end
    end

    // Scoreboards, sampled half a cycle after the drive edge
    always @(negedge clk) begin : monitor
        logic req_now [noc_pkg::NUM_PORTS][noc_pkg::NUM_PORTS];
        int   taken   [noc_pkg::NUM_PORTS];
        int   src;
        int   pkt;
        int   idx;
        int   pos;
        int   due;
        if (rst_n === 1'b1) begin
            // Which outputs each buffered head is asking for
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                taken[i] = 0;
                for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                    req_now[i][o] = (injected[i] > delivered[i]) && (route_q[i][0] == o);
                end
            end
            for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                if (credit_in[o]) outstanding[o]--;
                if (!running) check_bit(send_out[o], 1'b0, $sformatf("send_out[%0d] idle", o));
                if (send_out[o] === 1'b1) begin
                    src = int'(data_out[o][31:24]);
                    pkt = int'(data_out[o][23:8]);
                    idx = int'(data_out[o][7:0]);
                    if (src >= noc_pkg::NUM_PORTS || pkt >= NUM_ROWS || route_q[src].size() == 0) begin
                        abort_run($sformatf("Output %0d sent a flit that was never injected", o));
                    end
                    check_port(noc_pkg::port_idx_t'(o), route_q[src][0], "output port");
                    pos = -1;
                    for (int k = exp_q[o].size() - 1; k >= 0; k--) begin
                        if (int'(exp_q[o][k][31:24]) == src) pos = k;
                    end
                    if (pos < 0) begin
                        abort_run($sformatf("Output %0d sent an unexpected flit", o));
                    end
                    check_flit(data_out[o], exp_q[o][pos], "flit payload");
                    exp_q[o].delete(pos);
                    check_dest(dest_out[o], ROWS[pkt].dest, "dest_out");
                    check_bit(is_tail_out[o], (idx == int'(ROWS[pkt].len) - 1), "is_tail_out");
                    // No interleaving inside a packet
                    if (lock_src[o] >= 0) begin
                        check_port(noc_pkg::port_idx_t'(src), noc_pkg::port_idx_t'(lock_src[o]),
                                   "source inside a packet");
                    end else begin
                        // Last winner drops below every other requester
                        if (last_src[o] == src) begin
                            for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
                                if (j != src) check_bit(req_now[j][o], 1'b0, "waiting input passed over");
                            end
                        end
                        last_src[o] = src;
                    end
                    lock_src[o] = is_tail_out[o] ? -1 : src;
                    void'(route_q[src].pop_front());
                    delivered[src]++;
                    taken[src]++;
                    outstanding[o]++;
                    if (outstanding[o] > noc_pkg::BUFFER_DEPTH) begin
                        abort_run($sformatf("Output %0d sent more flits than it had credits", o));
                    end
                    due = cycle + (ROWS[pkt].bp ? 1 + int'($unsigned($random(seed)) % 6) : 1);
                    if (ret_q[o].size() > 0 && due <= ret_q[o][$]) due = ret_q[o][$] + 1;
                    ret_q[o].push_back(due);
                end
            end
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                check_bit(credit_out[i], (taken[i] == 1), $sformatf("credit_out[%0d]", i));
                if (credit_out[i]) begin
                    credits[i]++;
                    pulses[i]++;
                end
                if (send_in[i]) injected[i]++;
            end
        end
    end

    initial begin : main
        int             waited;
        int             o;
        noc_pkg::flit_t f;
        rst_n   = 1'b0;
        running = 1'b0;
        cycle   = 0;
        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            data_in[i]    = '0;
            dest_in[i]    = '0;
            is_tail_in[i] = 1'b0;
            send_in[i]    = 1'b0;
            credit_in[i]  = 1'b0;
        end
        // Every table row into the send queues and the scoreboards
        for (int r = 0; r < NUM_ROWS; r++) begin
            o = int'(noc_pkg::ROUTE_TABLE[ROWS[r].dest]);
            for (int k = 0; k < int'(ROWS[r].len); k++) begin
                f = make_flit(int'(ROWS[r].src), r, k);
                send_q[ROWS[r].src].push_back(f);
                route_q[ROWS[r].src].push_back(noc_pkg::port_idx_t'(o));
                exp_q[o].push_back(f);
                expected_flits[ROWS[r].src]++;
            end
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet window before traffic
        repeat (4) @(posedge clk);
        running <= 1'b1;
        waited = 0;
        while (!all_done() && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!all_done()) begin
            abort_run($sformatf("Timeout: traffic still in flight after %0d cycles", waited));
        end else begin
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                check_count(pulses[i], expected_flits[i], $sformatf("credit pulses input %0d", i));
            end
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- src.f
src/noc_pkg.sv
src/flit_fifo.sv
src/input_unit.sv
src/matrix_arbiter.sv
src/output_unit.sv
src/noc_router.sv
test/noc_router_tb.sv
